// ==== vlog.f ====
+incdir+rtl
rtl/message_extractor_pkg.sv
rtl/frame_parser.sv
rtl/message_packer.sv
rtl/message_extractor.sv
test/message_extractor_properties.sv
test/tb_message_extractor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the message extractor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_message_extractor \
    -o sim_message_extractor || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/sim_message_extractor 2>&1)"
echo "$sim_output"

echo "$sim_output" | grep -qx "Everything OK" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// ==== test/tb_message_extractor.sv ====
`timescale 1ns/1ps
`include "message_extractor_macros.svh"

module tb_message_extractor;

    import message_extractor_pkg::*;

    localparam int NUM_ROWS      = 10;
    localparam int DRAIN_TIMEOUT = 200;     // Cycles allowed for the last messages

    logic       clk;
    logic       reset_n;
    logic       in_valid;
    logic       in_startofpacket;
    logic       in_endofpacket;
    beat_t      in_data;
    empty_t     in_empty;
    logic       out_valid;
    msg_data_t  out_data;
    byte_mask_t out_bytemask;

    // Columns: count, len0, len1, len2, len3, pad bytes, gap mode, truncate
    // Gap mode 0 is back to back, 1 one idle cycle per beat, 2 zero to two idle cycles
    int rows [NUM_ROWS][8] = '{
        '{1,  8,  0,  0,  0, 0, 0, 0},      // Shortest message
        '{1, 32,  0,  0,  0, 0, 0, 0},      // Longest message
        '{4,  9, 13,  8, 31, 0, 0, 0},      // Length fields at offsets 2, 5, 4, 6
        '{4, 11, 10, 15,  8, 3, 1, 0},      // Field straddles beats at offset 7
        '{3, 20,  8, 12,  0, 5, 2, 0},      // Fields at offsets 0 and 2
        '{4,  8,  8,  8,  8, 0, 0, 0},      // Completions on consecutive beats
        '{3, 13, 14, 25,  0, 0, 0, 1},      // Offset 1, last message cut short
        '{2, 32, 32,  0,  0, 2, 1, 0},      // Full last beat
        '{2,  8, 16,  0,  0, 4, 2, 1},
        '{1, 24,  0,  0,  0, 0, 0, 0}
    };

    int unsigned lcg_state = 32'h9c90_856f;
    int          cycle = 0;
    int          received = 0;
    int          expected_total = 0;

    msg_data_t   exp_data_q[$];
    byte_mask_t  exp_mask_q[$];
    int          exp_due_q[$];              // Cycle in which out_valid must be seen
    logic [7:0]  pkt_bytes[$];              // Packet in wire order
    int          end_beat_q[$];             // Beat holding the last byte of each message

    message_extractor i_message_extractor (
        .clk              (clk),
        .reset_n          (reset_n),
        .in_valid         (in_valid),
        .in_startofpacket (in_startofpacket),
        .in_endofpacket   (in_endofpacket),
        .in_data          (in_data),
        .in_empty         (in_empty),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_bytemask     (out_bytemask)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [7:0] next_random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input msg_data_t got, input msg_data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t got, input byte_mask_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input msg_len_t got, input msg_len_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Serializes one table row and queues the messages it must produce
    task automatic build_packet(input int r);
        int         count;
        int         len;
        int         keep;
        msg_data_t  data;
        byte_mask_t mask;
        logic [7:0] b;

        count = rows[r][0];
        pkt_bytes.delete();
        end_beat_q.delete();
        pkt_bytes.push_back(8'(count >> 8));
        pkt_bytes.push_back(8'(count));
        for (int m = 0; m < count; m++) begin
            len  = rows[r][1 + m];
            // A cut message lacks only its last byte, so junk past in_empty would finish it
            keep = (rows[r][7] != 0 && m == count - 1) ? len - 1 : len;
            pkt_bytes.push_back(8'(len >> 8));
            pkt_bytes.push_back(8'(len));
            data = '0;
            mask = byte_mask_t'((64'd1 << len) - 64'd1);
            for (int k = 0; k < keep; k++) begin
                b = next_random_byte();
                pkt_bytes.push_back(b);
                data[8*(len-1-k) +: 8] = b;     // First byte lands highest
            end
            if (keep == len) begin
                exp_data_q.push_back(data);
                exp_mask_q.push_back(mask);
                end_beat_q.push_back((pkt_bytes.size() - 1) / `BEAT_BYTES);
                expected_total++;
            end
        end
        if (rows[r][7] == 0) begin
            for (int k = 0; k < rows[r][5]; k++) begin
                pkt_bytes.push_back(next_random_byte());    // Trailing padding
            end
        end
    endtask

    task automatic drive_idle();
        in_valid         = 1'b0;
        in_startofpacket = 1'b0;
        in_endofpacket   = 1'b0;
        in_empty         = '0;
        for (int k = 0; k < `BEAT_BYTES; k++) begin
            in_data[8*k +: 8] = next_random_byte();     // Junk, must be ignored
        end
    endtask

    task automatic drive_packet(input int r);
        int nbytes;
        int nbeats;
        int idx;
        int idle;

        nbytes = pkt_bytes.size();
        nbeats = (nbytes + `BEAT_BYTES - 1) / `BEAT_BYTES;
        for (int bt = 0; bt < nbeats; bt++) begin
            @(posedge clk);
            #1;
            in_valid         = 1'b1;
            in_startofpacket = (bt == 0);
            in_endofpacket   = (bt == nbeats - 1);
            in_empty         = (bt == nbeats - 1) ?
                               empty_t'(nbeats * `BEAT_BYTES - nbytes) : '0;
            for (int k = 0; k < `BEAT_BYTES; k++) begin
                idx = bt * `BEAT_BYTES + k;
                // Wire byte k sits k bytes below the top of the beat
                in_data[8*(`BEAT_BYTES-1-k) +: 8] =
                    (idx < nbytes) ? pkt_bytes[idx] : next_random_byte();
            end
            while (end_beat_q.size() != 0 && end_beat_q[0] == bt) begin
                void'(end_beat_q.pop_front());
                exp_due_q.push_back(cycle + 1);     // Accepted at the next edge
            end
            if (rows[r][6] == 1) begin
                idle = 1;
            end else if (rows[r][6] == 2) begin
                idle = int'(next_random_byte() % 8'd3);
            end else begin
                idle = 0;
            end
            repeat (idle) begin
                @(posedge clk);
                #1;
                drive_idle();
            end
        end
    endtask

    // Every out_valid pulse is matched against the next expected message
    always @(negedge clk) begin
        if (reset_n) begin
            if (out_valid) begin
                if (exp_data_q.size() == 0 || exp_due_q.size() == 0) begin
                    stop_with_failure("out_valid pulsed while no message was expected");
                end else if (exp_due_q[0] != cycle) begin
                    stop_with_failure($sformatf("out_valid pulsed in cycle %0d, expected in %0d",
                                                cycle, exp_due_q[0]));
                end else begin
                    check_data("out_data", out_data, exp_data_q.pop_front());
                    check_mask("out_bytemask", out_bytemask, exp_mask_q.pop_front());
                    void'(exp_due_q.pop_front());
                    received++;
                end
            end else if (received == 0) begin
                check_data("out_data", out_data, '0);           // Still at reset value
                check_mask("out_bytemask", out_bytemask, '0);
            end
        end
    end

    initial begin
        int waited;

        reset_n          = 1'b0;
        in_valid         = 1'b0;
        in_startofpacket = 1'b0;
        in_endofpacket   = 1'b0;
        in_data          = '0;
        in_empty         = '0;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            build_packet(r);
            drive_packet(r);
        end
        @(posedge clk);
        #1;
        drive_idle();

        waited = 0;
        while (received < expected_total && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);      // Room for a stray late pulse

        // Messages still missing after the drain show up as a short count
        check_count("received messages", msg_len_t'(received), msg_len_t'(expected_total));
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== test/message_extractor_properties.sv ====
`timescale 1ns/1ps

module message_extractor_properties (
    input logic                              clk,
    input logic                              reset_n,
    input logic                              out_valid,
    input message_extractor_pkg::msg_data_t  out_data,
    input message_extractor_pkg::byte_mask_t out_bytemask
);

    import message_extractor_pkg::*;

    msg_data_t bit_mask;            // Byte mask widened to one bit per data bit

    always_comb begin
        for (int i = 0; i < $bits(msg_data_t); i++) begin
            bit_mask[i] = out_bytemask[i / 8];
        end
    end

    // A run of low ones has no set bit left after adding one
    mask_low_run: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> ((out_bytemask & (out_bytemask + 32'd1)) == '0) &&
                      ($countones(out_bytemask) >= 8) &&
                      ($countones(out_bytemask) <= 32))
        else $error("out_bytemask is not a run of 8 to 32 low ones");

    data_clear_above_mask: assert property (@(posedge clk) disable iff (!reset_n)
        (out_data & ~bit_mask) == '0)
        else $error("out_data has bits set above out_bytemask");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |=> !out_valid)
        else $error("out_valid high in the cycle after reset release");

endmodule

bind message_extractor message_extractor_properties i_message_extractor_properties (
    .clk          (clk),
    .reset_n      (reset_n),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_bytemask (out_bytemask)
);

// ==== rtl/message_extractor.sv ====
`timescale 1ns/1ps

module message_extractor (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              in_valid,
    input  logic                              in_startofpacket,
    input  logic                              in_endofpacket,
    input  message_extractor_pkg::beat_t      in_data,
    input  message_extractor_pkg::empty_t     in_empty,
    output logic                              out_valid,
    output message_extractor_pkg::msg_data_t  out_data,
    output message_extractor_pkg::byte_mask_t out_bytemask
);

    import message_extractor_pkg::*;

    beat_class_t byte_class;        // Per-byte role of the current beat
    logic        msg_done;
    logic        pkt_abort;

    // Framing, zero latency
    frame_parser i_frame_parser (
        .clk              (clk),
        .reset_n          (reset_n),
        .in_valid         (in_valid),
        .in_startofpacket (in_startofpacket),
        .in_endofpacket   (in_endofpacket),
        .in_data          (in_data),
        .in_empty         (in_empty),
        .byte_class       (byte_class),
        .msg_done         (msg_done),
        .pkt_abort        (pkt_abort)
    );

    // Payload assembly and registered outputs
    message_packer i_message_packer (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_data      (in_data),
        .byte_class   (byte_class),
        .msg_done     (msg_done),
        .pkt_abort    (pkt_abort),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_bytemask (out_bytemask)
    );

endmodule

// ==== rtl/message_packer.sv ====
`timescale 1ns/1ps
`include "message_extractor_macros.svh"

module message_packer (
    input  logic                               clk,
    input  logic                               reset_n,
    input  message_extractor_pkg::beat_t       in_data,
    input  message_extractor_pkg::beat_class_t byte_class,
    input  logic                               msg_done,
    input  logic                               pkt_abort,
    output logic                               out_valid,
    output message_extractor_pkg::msg_data_t   out_data,
    output message_extractor_pkg::byte_mask_t  out_bytemask
);

    import message_extractor_pkg::*;

    msg_data_t  acc_data;           // Message in progress, right aligned
    byte_mask_t acc_mask;

    msg_data_t  cur_data;           // Accumulator plus this beat's CUR bytes
    byte_mask_t cur_mask;
    msg_data_t  nxt_data;           // NEXT bytes only, seed for the next message
    byte_mask_t nxt_mask;

    // Shift bytes in wire order, earlier bytes end up higher
    always_comb begin
        logic [7:0] cur_byte;

        cur_data = acc_data;
        cur_mask = acc_mask;
        nxt_data = '0;
        nxt_mask = '0;

        for (int j = `BEAT_BYTES - 1; j >= 0; j--) begin
            cur_byte = in_data[8*j +: 8];
            if (byte_class[j] == BYTE_CUR) begin
                cur_data = {cur_data[`MSG_MAX_BYTES*8-9:0], cur_byte};
                cur_mask = {cur_mask[`MSG_MAX_BYTES-2:0], 1'b1};
            end else if (byte_class[j] == BYTE_NEXT) begin
                nxt_data = {nxt_data[`MSG_MAX_BYTES*8-9:0], cur_byte};
                nxt_mask = {nxt_mask[`MSG_MAX_BYTES-2:0], 1'b1};
            end
        end
    end

    // Accumulator restarts clean so out_data stays zero above the mask
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            acc_data <= '0;
            acc_mask <= '0;
        end else if (pkt_abort) begin
            acc_data <= '0;                 // Partial message dropped
            acc_mask <= '0;
        end else if (msg_done) begin
            acc_data <= nxt_data;
            acc_mask <= nxt_mask;
        end else begin
            acc_data <= cur_data;
            acc_mask <= cur_mask;
        end
    end

    // Finished message is presented one cycle after its last byte
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid    <= 1'b0;
            out_data     <= '0;
            out_bytemask <= '0;
        end else begin
            out_valid <= msg_done;
            if (msg_done) begin
                out_data     <= cur_data;   // Held until the next message
                out_bytemask <= cur_mask;
            end
        end
    end

endmodule

// ==== rtl/frame_parser.sv ====
`timescale 1ns/1ps
`include "message_extractor_macros.svh"

module frame_parser (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               in_valid,
    input  logic                               in_startofpacket,
    input  logic                               in_endofpacket,
    input  message_extractor_pkg::beat_t       in_data,
    input  message_extractor_pkg::empty_t      in_empty,
    output message_extractor_pkg::beat_class_t byte_class,
    output logic                               msg_done,
    output logic                               pkt_abort
);

    import message_extractor_pkg::*;

    logic       pkt_active;         // Between an accepted SOP and its EOP
    msg_len_t   msgs_left;          // Messages whose length field is not read yet
    msg_len_t   pay_left;           // Payload bytes still owed by the open message
    logic       len_hi_pend;        // Length field split, low byte comes next beat
    logic [7:0] len_hi;             // Held high byte of a split length field

    logic       accept;
    logic       first_beat;

    // Walk results for the register update
    msg_len_t   nxt_msgs_left;
    msg_len_t   nxt_pay_left;
    logic       nxt_len_hi_pend;
    logic [7:0] nxt_len_hi;
    logic       walk_done;
    logic       walk_open;

    // SOP starts a packet only when idle, inside a packet an SOP beat is dropped
    assign first_beat = !pkt_active;
    assign accept     = in_valid &&
                        ((first_beat && in_startofpacket) ||
                         (!first_beat && !in_startofpacket));

    // Byte walk in wire order, byte 7 first
    always_comb begin
        logic [7:0]  cur_byte;
        logic        in_range;
        logic        seen_end;
        msg_len_t    v_msgs;
        msg_len_t    v_pay;
        logic        v_pend;
        logic [7:0]  v_hi;
        byte_class_e cls;

        seen_end = 1'b0;

        if (first_beat) begin
            v_msgs = in_data[`BEAT_BYTES*8-1 -: `COUNT_FIELD_BYTES*8];
            v_pay  = '0;
            v_pend = 1'b0;
            v_hi   = '0;
        end else begin
            v_msgs = msgs_left;
            v_pay  = pay_left;
            v_pend = len_hi_pend;
            v_hi   = len_hi;
        end

        for (int j = `BEAT_BYTES - 1; j >= 0; j--) begin
            cur_byte = in_data[8*j +: 8];
            in_range = !in_endofpacket || (3'(j) >= in_empty);
            cls      = BYTE_SKIP;

            if (!accept || !in_range) begin
                cls = BYTE_SKIP;                        // Idle cycle or empty tail
            end else if (first_beat && (j >= `BEAT_BYTES - `COUNT_FIELD_BYTES)) begin
                cls = BYTE_SKIP;                        // Message count field
            end else if (v_pay != '0) begin
                cls   = seen_end ? BYTE_NEXT : BYTE_CUR;
                v_pay = v_pay - 16'd1;
                if (v_pay == '0) begin
                    seen_end = 1'b1;                    // Boundary inside this beat
                end
            end else if (v_msgs == '0) begin
                cls = BYTE_SKIP;                        // Count exhausted, trailing bytes
            end else if (!v_pend) begin
                v_hi   = cur_byte;                      // Length high byte
                v_pend = 1'b1;
            end else begin
                v_pay  = {v_hi, cur_byte};              // Length complete, message opens
                v_pend = 1'b0;
                v_msgs = v_msgs - 16'd1;
            end

            byte_class[j] = cls;
        end

        nxt_msgs_left   = v_msgs;
        nxt_pay_left    = v_pay;
        nxt_len_hi_pend = v_pend;
        nxt_len_hi      = v_hi;
        walk_done       = seen_end;
        walk_open       = (v_pay != '0) || v_pend;
    end

    // At most one message can end per beat, given the minimum length
    assign msg_done  = accept && walk_done;
    assign pkt_abort = accept && in_endofpacket && walk_open;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pkt_active  <= 1'b0;
            msgs_left   <= '0;
            pay_left    <= '0;
            len_hi_pend <= 1'b0;
        end else if (accept) begin
            pkt_active  <= !in_endofpacket;
            msgs_left   <= nxt_msgs_left;
            pay_left    <= nxt_pay_left;
            len_hi_pend <= nxt_len_hi_pend;
        end
    end

    // High length byte carried to the next beat
    always_ff @(posedge clk) begin
        if (accept) begin
            len_hi <= nxt_len_hi;
        end
    end

endmodule

// ==== rtl/message_extractor_pkg.sv ====
package message_extractor_pkg;

    // Stream side
    typedef logic [63:0]  beat_t;       // Byte 7 is the first byte on the wire
    typedef logic [2:0]   empty_t;      // Unused low bytes of the last beat

    // Message side, payload right aligned
    typedef logic [255:0] msg_data_t;
    typedef logic [31:0]  byte_mask_t;  // One bit per payload byte
    typedef logic [15:0]  msg_len_t;    // Length field or message count

    // Role of one beat byte as seen by the packer
    typedef enum logic [1:0] {
        BYTE_SKIP = 2'd0,               // Header, length field, padding or unused
        BYTE_CUR  = 2'd1,               // Payload of the message in progress
        BYTE_NEXT = 2'd2                // Payload of a message opened in this beat
    } byte_class_e;

    // Element j classifies in_data[8*j +: 8]
    typedef byte_class_e [7:0] beat_class_t;

endpackage

// ==== rtl/message_extractor_macros.svh ====
`ifndef MESSAGE_EXTRACTOR_MACROS_SVH
`define MESSAGE_EXTRACTOR_MACROS_SVH

// Input stream geometry
`define BEAT_BYTES 8             // Bytes carried by one input beat

// Message payload limits
`define MSG_MAX_BYTES 32         // Largest payload, fills the output register
`define MSG_MIN_BYTES 8          // Smallest payload, one message end per beat at most

// Header fields, both big endian on the wire
`define LEN_FIELD_BYTES 2        // Length field in front of every message
`define COUNT_FIELD_BYTES 2      // Message count at the start of a packet

`endif
